//--- bench/blur_tb.sv
`timescale 1ns/1ps
`include "blur_config.svh"

module blur_tb;

    localparam int MAX_CYCLES = 20000;   // All tests with margin

    logic                    clk;
    logic                    reset;
    logic [`BLUR_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic                    wvalid;
    logic                    wready;
    blur_pkg::axi_resp_t     bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`BLUR_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [31:0]             rdata;
    blur_pkg::axi_resp_t     rresp;
    logic                    rvalid;
    logic                    rready;
    blur_pkg::pixel_t        pix_in;
    logic                    pix_valid;
    logic                    pix_sol;
    logic [3:0]              table_state;
    logic                    image_ready;
    blur_pkg::pixel_t        data_out;
    logic                    data_valid;
    logic                    sender_reset;

    int               cycle_cnt;
    int               pass_cnt;
    int               fail_cnt;
    int               test_fails;   // fail_cnt when the current test began
    int               hist_col;     // Model column of the next pixel
    blur_pkg::pixel_t hist_p1;
    blur_pkg::pixel_t hist_p2;

    blur_top u_blur_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run still busy after %0d clock cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pixel(input string name, input blur_pkg::pixel_t exp,
                               input blur_pkg::pixel_t act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input blur_pkg::sel_state_t exp,
                               input blur_pkg::sel_state_t act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_resp(input string name, input blur_pkg::axi_resp_t exp,
                              input blur_pkg::axi_resp_t act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        if (fail_cnt == test_fails) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d failing checks", name, fail_cnt - test_fails);
        end
        test_fails = fail_cnt;
    endtask

    // Handshake seen through bvalid, sampled on the falling edge
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             output blur_pkg::axi_resp_t resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        @(posedge clk);   // Response retires, bready is high
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                            output blur_pkg::axi_resp_t resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        @(posedge clk);
    endtask

    task automatic write_readback(input logic [4:0] addr, input logic [31:0] data,
                                  input logic [31:0] exp);
        blur_pkg::axi_resp_t resp;
        logic [31:0]         word;
        axi_write(addr, data, resp);
        check_resp("bresp", blur_pkg::RESP_OKAY, resp);
        axi_read(addr, word, resp);
        check_resp("rresp", blur_pkg::RESP_OKAY, resp);
        check_word("rdata", exp, word);
    endtask

    task automatic read_state(output blur_pkg::sel_state_t st);
        blur_pkg::axi_resp_t resp;
        logic [31:0]         word;
        axi_read(blur_pkg::REG_STATUS, word, resp);
        st = blur_pkg::sel_state_t'(word[1:0]);
    endtask

    task automatic wait_for_state(input blur_pkg::sel_state_t target);
        blur_pkg::sel_state_t st;
        int                   polls;
        polls = 0;
        read_state(st);
        while (st != target && polls < 40) begin
            read_state(st);
            polls++;
        end
        check_state("status", target, st);
    endtask

    task automatic pulse_ready();
        @(negedge clk);
        image_ready = 1'b1;
        @(negedge clk);
        image_ready = 1'b0;
    endtask

    // Expected output of the horizontal filter for center pixel c
    task automatic model_blur(input blur_pkg::pixel_t c, input logic sol, input int lo,
                              input int hi, output blur_pkg::pixel_t exp);
        blur_pkg::pixel_t n1;
        blur_pkg::pixel_t n2;
        if (sol) begin
            hist_col = 0;
        end
        n1 = (hist_col == 0) ? c : hist_p1;
        n2 = (hist_col == 0) ? c : ((hist_col == 1) ? hist_p1 : hist_p2);
        if (hist_col >= lo && hist_col <= hi) begin
            exp.r = 4'((int'(n2.r) + 2 * int'(n1.r) + int'(c.r)) / 4);
            exp.g = 4'((int'(n2.g) + 2 * int'(n1.g) + int'(c.g)) / 4);
            exp.b = 4'((int'(n2.b) + 2 * int'(n1.b) + int'(c.b)) / 4);
        end else begin
            exp = c;
        end
        hist_p2 = hist_p1;
        hist_p1 = c;
        hist_col++;
    endtask

    task automatic test_registers();
        blur_pkg::axi_resp_t resp;
        logic [31:0]         word;
        axi_read(blur_pkg::REG_CTRL, word, resp);
        check_word("ctrl default", 32'h0000_0000, word);
        check_resp("rresp", blur_pkg::RESP_OKAY, resp);
        axi_read(blur_pkg::REG_WAIT, word, resp);
        check_word("wait_time default", 32'd50_000_000, word);
        axi_read(blur_pkg::REG_RESET, word, resp);
        check_word("reset_time default", 32'd50_000_000, word);
        axi_read(blur_pkg::REG_WINDOW, word, resp);
        check_word("window default", 32'h027F_0000, word);   // x_hi 639, x_lo 0
        axi_read(blur_pkg::REG_STATUS, word, resp);
        check_word("status default", 32'd0, word);
        write_readback(blur_pkg::REG_WAIT, 32'h0123_4567, 32'h0123_4567);
        write_readback(blur_pkg::REG_RESET, 32'hFFFF_FFFF, 32'h03FF_FFFF);
        write_readback(blur_pkg::REG_WINDOW, 32'hFFFF_FFFF, 32'h03FF_03FF);
        write_readback(blur_pkg::REG_CTRL, 32'hFFFF_FFFF, 32'h0000_00F1);
        axi_write(blur_pkg::REG_CTRL, 32'd0, resp);
        axi_write(5'h14, 32'h1, resp);
        check_resp("bresp unmapped", blur_pkg::RESP_SLVERR, resp);
        axi_read(5'h14, word, resp);
        check_resp("rresp unmapped", blur_pkg::RESP_SLVERR, resp);
        axi_write(blur_pkg::REG_STATUS, 32'h3, resp);
        check_resp("bresp status", blur_pkg::RESP_SLVERR, resp);
        axi_read(blur_pkg::REG_STATUS, word, resp);
        check_word("status after write", 32'd0, word);
        axi_read(blur_pkg::REG_WAIT, word, resp);
        check_word("wait_time after rejected writes", 32'h0123_4567, word);
        finish_test("register access");
    endtask

    task automatic test_blur_path();
        blur_pkg::axi_resp_t resp;
        blur_pkg::pixel_t    exp_pix;
        logic [31:0]         rnd;
        axi_write(blur_pkg::REG_WINDOW, 32'h0008_0003, resp);   // Columns 3 to 8
        axi_write(blur_pkg::REG_WAIT, 32'd4, resp);
        axi_write(blur_pkg::REG_CTRL, 32'h0000_0051, resp);     // Match 5, enabled
        @(negedge clk);
        table_state = 4'd5;
        pulse_ready();
        wait_for_state(blur_pkg::SEL_BLUR);
        for (int i = 0; i <= 36; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_bit("data_valid", 1'b1, data_valid);
                check_pixel("data_out", exp_pix, data_out);
            end
            rnd       = $urandom();
            pix_in    = rnd[11:0];
            pix_valid = (i < 36);
            pix_sol   = (i % 12 == 0);   // Lines of 12 pixels
            model_blur(pix_in, pix_sol, 3, 8, exp_pix);
        end
        pix_sol = 1'b0;
        finish_test("blur path");
    endtask

    task automatic test_select_sequence();
        blur_pkg::axi_resp_t  resp;
        blur_pkg::sel_state_t st;
        blur_pkg::pixel_t     prev_pix;
        logic [31:0]          rnd;
        int                   wait_cycles;
        @(negedge clk);
        table_state = 4'd0;
        pulse_ready();
        axi_write(blur_pkg::REG_CTRL, 32'h0000_0050, resp);   // Match 5, disabled
        axi_write(blur_pkg::REG_WAIT, 32'd20, resp);
        @(negedge clk);
        table_state = 4'd5;
        pix_valid   = 1'b1;
        repeat (5) @(negedge clk);
        check_bit("data_valid idle", 1'b0, data_valid);
        read_state(st);
        check_state("status disabled", blur_pkg::SEL_IDLE, st);
        axi_write(blur_pkg::REG_CTRL, 32'h0000_0051, resp);
        read_state(st);
        check_state("status enabled", blur_pkg::SEL_RAW, st);
        for (int i = 0; i <= 8; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_bit("data_valid raw", 1'b1, data_valid);
                check_pixel("data_out raw", prev_pix, data_out);
            end
            rnd      = $urandom();
            pix_in   = rnd[11:0];
            pix_sol  = (i == 0);   // New line, so columns 3 to 8 fall in the window
            prev_pix = pix_in;
        end
        image_ready = 1'b1;
        @(negedge clk);
        image_ready = 1'b0;
        wait_cycles = 0;
        while (!data_valid && wait_cycles < 100) begin   // Gap until blurred frame starts
            check_pixel("data_out wait", '0, data_out);
            wait_cycles++;
            @(negedge clk);
        end
        check_word("wait cycles", 32'd21, wait_cycles);
        read_state(st);
        check_state("status after wait", blur_pkg::SEL_BLUR, st);
        table_state = 4'd0;
        pix_valid   = 1'b0;
        pulse_ready();
        read_state(st);
        check_state("status after frame", blur_pkg::SEL_IDLE, st);
        finish_test("select sequence");
    endtask

    task automatic test_reset_pulse();
        blur_pkg::axi_resp_t resp;
        int                  last_low;
        int                  lows;
        axi_write(blur_pkg::REG_RESET, 32'd7, resp);
        repeat (10) begin
            @(negedge clk);
            check_bit("sender_reset idle", 1'b1, sender_reset);
        end
        table_state = 4'd5;
        last_low    = -1;
        lows        = 0;
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            if (!sender_reset) begin
                if (last_low >= 0) begin
                    check_word("pulse spacing", 32'd8, i - last_low);
                end
                last_low = i;
                lows++;
            end
        end
        check_bit("pulses seen in raw", 1'b1, lows >= 4);
        image_ready = 1'b1;
        @(negedge clk);
        image_ready = 1'b0;
        table_state = 4'd0;
        repeat (15) begin
            check_bit("sender_reset wait", 1'b1, sender_reset);
            @(negedge clk);
        end
        wait_for_state(blur_pkg::SEL_BLUR);
        pulse_ready();
        repeat (10) begin
            check_bit("sender_reset idle", 1'b1, sender_reset);
            @(negedge clk);
        end
        finish_test("reset pulse");
    endtask

    task automatic test_back_pressure();
        blur_pkg::axi_resp_t resp;
        logic [31:0]         word;
        @(negedge clk);
        bready  = 1'b0;
        rready  = 1'b0;
        awaddr  = blur_pkg::REG_WAIT;
        wdata   = 32'h0000_0AAA;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        awaddr = blur_pkg::REG_RESET;   // Second write queued behind the response
        wdata  = 32'h0000_0555;
        repeat (5) begin
            @(negedge clk);
            check_bit("bvalid held", 1'b1, bvalid);
            check_bit("awready held off", 1'b0, awready);
            check_bit("wready held off", 1'b0, wready);
            check_resp("bresp held", blur_pkg::RESP_OKAY, bresp);
        end
        bready = 1'b1;
        @(negedge clk);
        check_bit("bvalid retired", 1'b0, bvalid);
        while (!bvalid) begin
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_resp("bresp second", blur_pkg::RESP_OKAY, bresp);
        araddr  = blur_pkg::REG_WINDOW;
        arvalid = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        araddr = blur_pkg::REG_CTRL;
        repeat (5) begin
            @(negedge clk);
            check_bit("rvalid held", 1'b1, rvalid);
            check_bit("arready held off", 1'b0, arready);
            check_word("rdata held", 32'h0008_0003, rdata);
        end
        rready = 1'b1;
        @(negedge clk);
        check_bit("rvalid retired", 1'b0, rvalid);
        while (!rvalid) begin
            @(negedge clk);
        end
        arvalid = 1'b0;
        check_word("rdata ctrl", 32'h0000_0051, rdata);
        axi_read(blur_pkg::REG_WAIT, word, resp);
        check_word("wait_time after", 32'h0000_0AAA, word);
        axi_read(blur_pkg::REG_RESET, word, resp);
        check_word("reset_time after", 32'h0000_0555, word);
        finish_test("back-pressure");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = 32'd0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        pix_in      = '0;
        pix_valid   = 1'b0;
        pix_sol     = 1'b0;
        table_state = 4'd0;
        image_ready = 1'b0;
        cycle_cnt   = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_fails  = 0;
        hist_col    = 0;
        hist_p1     = '0;
        hist_p2     = '0;
        void'($urandom(32'hc587));
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_registers();
        test_blur_path();
        test_select_sequence();
        test_reset_pulse();
        test_back_pressure();
        $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- common/blur_config.svh
`ifndef BLUR_CONFIG_SVH
`define BLUR_CONFIG_SVH

// Datapath widths
`define BLUR_PIX_W      12              // RGB444 pixel
`define BLUR_COL_W      10              // Column counter
`define BLUR_CNT_W      26              // Wait and reset counters
`define BLUR_ADDR_W     5               // AXI4-Lite byte address

// Register offsets
`define BLUR_REG_CTRL   5'h00
`define BLUR_REG_WAIT   5'h04
`define BLUR_REG_RESET  5'h08
`define BLUR_REG_WINDOW 5'h0C
`define BLUR_REG_STATUS 5'h10

// Register reset values
`define BLUR_DEF_WAIT   26'd50_000_000  // One second at 50 MHz
`define BLUR_DEF_RESET  26'd50_000_000
`define BLUR_DEF_XLO    10'd0
`define BLUR_DEF_XHI    10'd639         // Full VGA line

`endif

//--- common/blur_pkg.sv
`include "blur_config.svh"

package blur_pkg;

    // One RGB444 pixel, red in the top nibble
    typedef struct packed {
        logic [`BLUR_PIX_W/3-1:0] r;
        logic [`BLUR_PIX_W/3-1:0] g;
        logic [`BLUR_PIX_W/3-1:0] b;
    } pixel_t;

    // Send-select FSM states, also reported in the status word
    typedef enum logic [1:0] {
        SEL_IDLE = 2'd0,
        SEL_RAW  = 2'd1,  // Unfiltered frame to sender
        SEL_WAIT = 2'd2,  // Gap between frames
        SEL_BLUR = 2'd3   // Blurred frame to sender
    } sel_state_t;

    // AXI4-Lite register map
    typedef enum logic [`BLUR_ADDR_W-1:0] {
        REG_CTRL   = `BLUR_REG_CTRL,
        REG_WAIT   = `BLUR_REG_WAIT,
        REG_RESET  = `BLUR_REG_RESET,
        REG_WINDOW = `BLUR_REG_WINDOW,
        REG_STATUS = `BLUR_REG_STATUS   // Read only
    } reg_addr_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- list.f
+incdir+common
common/blur_pkg.sv
regs/blur_regs.sv
logic/face_blur.sv
logic/image_send_select.sv
logic/blur_top.sv
bench/blur_tb.sv

//--- logic/blur_top.sv
`timescale 1ns/1ps
`include "blur_config.svh"

module blur_top (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [`BLUR_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output blur_pkg::axi_resp_t     bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`BLUR_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output blur_pkg::axi_resp_t     rresp,
    output logic                    rvalid,
    input  logic                    rready,

    input  blur_pkg::pixel_t        pix_in,
    input  logic                    pix_valid,
    input  logic                    pix_sol,       // First pixel of a line

    input  logic [3:0]              table_state,
    input  logic                    image_ready,

    output blur_pkg::pixel_t        data_out,
    output logic                    data_valid,
    output logic                    sender_reset
);

    logic                   enable;
    logic [3:0]             match_state;
    logic [`BLUR_CNT_W-1:0] wait_time;
    logic [`BLUR_CNT_W-1:0] reset_time;
    logic [`BLUR_COL_W-1:0] x_lo;
    logic [`BLUR_COL_W-1:0] x_hi;
    blur_pkg::sel_state_t   sel_state;     // Fed back to status
    blur_pkg::pixel_t       raw_pix;
    blur_pkg::pixel_t       blur_pix;
    logic                   blur_valid;

    blur_regs u_regs (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .sel_state(sel_state),
        .enable(enable), .match_state(match_state),
        .wait_time(wait_time), .reset_time(reset_time),
        .x_lo(x_lo), .x_hi(x_hi)
    );

    face_blur u_blur (
        .clk(clk), .reset(reset),
        .pix_in(pix_in), .pix_valid(pix_valid), .pix_sol(pix_sol),
        .x_lo(x_lo), .x_hi(x_hi),
        .raw_out(raw_pix), .blur_out(blur_pix), .blur_valid(blur_valid)
    );

    image_send_select u_select (
        .clk(clk), .reset(reset),
        .norm_in(raw_pix), .blur_in(blur_pix), .in_valid(blur_valid),
        .table_state(table_state), .image_ready(image_ready),
        .enable(enable), .match_state(match_state),
        .wait_time(wait_time), .reset_time(reset_time),
        .state_out(sel_state), .sender_reset(sender_reset),
        .data_out(data_out), .data_valid(data_valid)
    );

endmodule

//--- logic/face_blur.sv
`timescale 1ns/1ps
`include "blur_config.svh"

module face_blur (
    input  logic                    clk,
    input  logic                    reset,
    input  blur_pkg::pixel_t        pix_in,
    input  logic                    pix_valid,
    input  logic                    pix_sol,
    input  logic [`BLUR_COL_W-1:0]  x_lo,
    input  logic [`BLUR_COL_W-1:0]  x_hi,
    output blur_pkg::pixel_t        raw_out,
    output blur_pkg::pixel_t        blur_out,
    output logic                    blur_valid
);

    localparam int CH_W = `BLUR_PIX_W / 3;

    logic [`BLUR_COL_W-1:0] col_cnt;    // Column of the next pixel
    logic [`BLUR_COL_W-1:0] cur_col;    // Column of pix_in
    blur_pkg::pixel_t       p1;         // Previous pixel
    blur_pkg::pixel_t       p2;         // Pixel before that
    blur_pkg::pixel_t       tap1;
    blur_pkg::pixel_t       tap2;
    blur_pkg::pixel_t       avg_pix;
    logic                   in_window;

    // 1-2-1 weighted average of one channel, truncated
    function automatic logic [CH_W-1:0] ch_avg(
        input logic [CH_W-1:0] far_v,
        input logic [CH_W-1:0] near_v,
        input logic [CH_W-1:0] cur_v
    );
        logic [CH_W+1:0] sum;
        sum = {2'b00, far_v} + {1'b0, near_v, 1'b0} + {2'b00, cur_v};
        return sum[CH_W+1:2];
    endfunction

    assign cur_col = pix_sol ? '0 : col_cnt;

    // History is replicated from the center pixel at line start
    always_comb begin : tap_select
        if (cur_col == '0) begin
            tap1 = pix_in;
            tap2 = pix_in;
        end else if (cur_col == `BLUR_COL_W'(1)) begin
            tap1 = p1;
            tap2 = p1;
        end else begin
            tap1 = p1;
            tap2 = p2;
        end
    end

    always_comb begin : channel_avg
        avg_pix.r = ch_avg(tap2.r, tap1.r, pix_in.r);
        avg_pix.g = ch_avg(tap2.g, tap1.g, pix_in.g);
        avg_pix.b = ch_avg(tap2.b, tap1.b, pix_in.b);
    end

    assign in_window = (cur_col >= x_lo) && (cur_col <= x_hi);   // Inclusive bounds

    always_ff @(posedge clk) begin : col_track
        if (reset) begin
            col_cnt    <= '0;
            blur_valid <= 1'b0;
        end else begin
            blur_valid <= pix_valid;
            if (pix_valid) begin
                col_cnt <= cur_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin : pixel_pipe
        if (pix_valid) begin
            p1       <= pix_in;
            p2       <= p1;
            raw_out  <= pix_in;   // Kept in step with blur_out
            blur_out <= in_window ? avg_pix : pix_in;
        end
    end

endmodule

//--- logic/image_send_select.sv
`timescale 1ns/1ps
`include "blur_config.svh"

module image_send_select (
    input  logic                    clk,
    input  logic                    reset,
    input  blur_pkg::pixel_t        norm_in,
    input  blur_pkg::pixel_t        blur_in,
    input  logic                    in_valid,
    input  logic [3:0]              table_state,
    input  logic                    image_ready,   // Frame received by sender
    input  logic                    enable,
    input  logic [3:0]              match_state,
    input  logic [`BLUR_CNT_W-1:0]  wait_time,
    input  logic [`BLUR_CNT_W-1:0]  reset_time,
    output blur_pkg::sel_state_t    state_out,
    output logic                    sender_reset,  // Active low
    output blur_pkg::pixel_t        data_out,
    output logic                    data_valid
);

    blur_pkg::sel_state_t   state;
    blur_pkg::sel_state_t   next_state;
    logic [`BLUR_CNT_W-1:0] wait_cnt;
    logic [`BLUR_CNT_W-1:0] pulse_cnt;
    logic                   sending;
    logic                   pulse_hit;

    assign sending   = (state == blur_pkg::SEL_RAW) || (state == blur_pkg::SEL_BLUR);
    assign pulse_hit = sending && (pulse_cnt == reset_time);

    always_comb begin : fsm_next
        case (state)
            blur_pkg::SEL_IDLE:
                next_state = (enable && table_state == match_state) ?
                             blur_pkg::SEL_RAW : blur_pkg::SEL_IDLE;
            blur_pkg::SEL_RAW:
                next_state = image_ready ? blur_pkg::SEL_WAIT : blur_pkg::SEL_RAW;
            blur_pkg::SEL_WAIT:
                next_state = (wait_cnt == wait_time) ? blur_pkg::SEL_BLUR : blur_pkg::SEL_WAIT;
            blur_pkg::SEL_BLUR:
                next_state = image_ready ? blur_pkg::SEL_IDLE : blur_pkg::SEL_BLUR;
            default:
                next_state = blur_pkg::SEL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin : fsm_state
        if (reset) begin
            state <= blur_pkg::SEL_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Counts from 0 on entry, so WAIT lasts wait_time+1 cycles
    always_ff @(posedge clk) begin : wait_counter
        if (reset) begin
            wait_cnt <= '0;
        end else if (state == blur_pkg::SEL_WAIT) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin : pulse_counter
        if (reset) begin
            pulse_cnt <= '0;
        end else if (!sending || pulse_hit) begin
            pulse_cnt <= '0;   // Restart after each pulse
        end else begin
            pulse_cnt <= pulse_cnt + 1'b1;
        end
    end

    assign sender_reset = !pulse_hit;
    assign state_out    = state;

    always_comb begin : pixel_route
        case (state)
            blur_pkg::SEL_RAW: begin
                data_out   = norm_in;
                data_valid = in_valid;
            end
            blur_pkg::SEL_BLUR: begin
                data_out   = blur_in;
                data_valid = in_valid;
            end
            default: begin
                data_out   = '0;   // Nothing sent while idle or waiting
                data_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- regs/blur_regs.sv
`timescale 1ns/1ps
`include "blur_config.svh"

module blur_regs (
    input  logic                     clk,
    input  logic                     reset,

    input  logic [`BLUR_ADDR_W-1:0]  awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output blur_pkg::axi_resp_t      bresp,
    output logic                     bvalid,
    input  logic                     bready,

    input  logic [`BLUR_ADDR_W-1:0]  araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output blur_pkg::axi_resp_t      rresp,
    output logic                     rvalid,
    input  logic                     rready,

    input  blur_pkg::sel_state_t     sel_state,
    output logic                     enable,
    output logic [3:0]               match_state,
    output logic [`BLUR_CNT_W-1:0]   wait_time,
    output logic [`BLUR_CNT_W-1:0]   reset_time,
    output logic [`BLUR_COL_W-1:0]   x_lo,
    output logic [`BLUR_COL_W-1:0]   x_hi
);

    localparam int CNT_PAD = 32 - `BLUR_CNT_W;
    localparam int COL_PAD = 16 - `BLUR_COL_W;

    logic        wr_fire;
    logic        rd_fire;
    logic        wr_hit;    // Writable offset
    logic        rd_hit;    // Mapped offset
    logic [31:0] rd_word;

    // Address and data are taken together, and only with no response pending
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    assign arready = !rvalid;   // Hold off new reads while rdata is owed
    assign rd_fire = arvalid && arready;

    always_comb begin : write_decode
        case (awaddr)
            blur_pkg::REG_CTRL,
            blur_pkg::REG_WAIT,
            blur_pkg::REG_RESET,
            blur_pkg::REG_WINDOW: wr_hit = 1'b1;
            default:              wr_hit = 1'b0;   // Status and holes
        endcase
    end

    always_comb begin : read_decode
        rd_hit  = 1'b1;
        rd_word = 32'd0;
        case (araddr)
            blur_pkg::REG_CTRL:   rd_word = {24'd0, match_state, 3'd0, enable};
            blur_pkg::REG_WAIT:   rd_word = {{CNT_PAD{1'b0}}, wait_time};
            blur_pkg::REG_RESET:  rd_word = {{CNT_PAD{1'b0}}, reset_time};
            blur_pkg::REG_WINDOW: rd_word = {{COL_PAD{1'b0}}, x_hi, {COL_PAD{1'b0}}, x_lo};
            blur_pkg::REG_STATUS: rd_word = {30'd0, sel_state};   // Live FSM state
            default:              rd_hit  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin : ctrl_regs
        if (reset) begin
            enable      <= 1'b0;
            match_state <= 4'd0;
            wait_time   <= `BLUR_DEF_WAIT;
            reset_time  <= `BLUR_DEF_RESET;
            x_lo        <= `BLUR_DEF_XLO;
            x_hi        <= `BLUR_DEF_XHI;
        end else if (wr_fire) begin
            case (awaddr)
                blur_pkg::REG_CTRL: begin
                    enable      <= wdata[0];
                    match_state <= wdata[7:4];
                end
                blur_pkg::REG_WAIT: begin
                    wait_time <= wdata[`BLUR_CNT_W-1:0];
                end
                blur_pkg::REG_RESET: begin
                    reset_time <= wdata[`BLUR_CNT_W-1:0];
                end
                blur_pkg::REG_WINDOW: begin
                    x_lo <= wdata[`BLUR_COL_W-1:0];
                    x_hi <= wdata[16+`BLUR_COL_W-1:16];
                end
                default: begin
                    enable <= enable;   // Rejected with SLVERR
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin : write_resp
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin : write_resp_code
        if (wr_fire) begin
            bresp <= wr_hit ? blur_pkg::RESP_OKAY : blur_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin : read_resp
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data captured once per read, stable under back-pressure
    always_ff @(posedge clk) begin : read_data
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_hit ? blur_pkg::RESP_OKAY : blur_pkg::RESP_SLVERR;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the blur testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=blur_sim

verilator --binary --timing --top-module blur_tb -f list.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

exit 0
